// ==== common/board_cfg.svh ====
`ifndef BOARD_CFG_SVH
`define BOARD_CFG_SVH

//----------------------------------------------------------------------
// clocking

`define CLK_MHZ          27                  // board oscillator

// slow lab tick shortened so a few ticks fit in a short run
`define LAB_TICK_CYCLES  6000

`define SIO_HALF_CYCLES  (`CLK_MHZ / 6)      // clk cycles per sio_clk half period

//----------------------------------------------------------------------
// TM1638 frame layout

`define TM_DIGITS        8                   // seven-segment digits on the module
`define TM_DATA_BYTES    (2 * `TM_DIGITS)    // segment byte + led byte per digit
`define TM_KEY_BYTES     4                   // bytes returned by a key scan

`endif

// ==== common/board_pkg.sv ====
package board_pkg;

    `include "board_cfg.svh"

    //------------------------------------------------------------------
    // TM1638 sequencer states and command bytes

    typedef enum logic [3:0] {
        st_idle,
        st_cmd_write,
        st_stb_gap1,
        st_addr,
        st_data,
        st_stb_gap2,
        st_cmd_disp,
        st_stb_gap3,
        st_cmd_read,
        st_keys,
        st_stb_gap4
    } tm_state_e;

    typedef enum logic [7:0] {
        cmd_write_auto = 8'h40,  // data write, auto address increment
        cmd_read_keys  = 8'h42,
        cmd_addr0      = 8'hC0,
        cmd_disp_on    = 8'h8F   // display on, full brightness
    } tm_cmd_e;

    //------------------------------------------------------------------
    // payloads

    typedef struct packed {
        logic [`TM_DIGITS - 1:0][7:0] segments;  // hgfedcba per digit
        logic [`TM_DIGITS - 1:0]      leds;
        logic [`TM_DIGITS - 1:0]      digit_en;
    } disp_frame_t;

    typedef struct packed {
        logic [7:0] count;
        logic [7:0] abcdefgh;    // a at the msb
        logic [7:0] digit;       // one-hot scan select
        logic [7:0] led;
    } lab_out_t;

    //------------------------------------------------------------------

    function automatic logic [7:0] seg7_hex(input logic [3:0] nibble);
        logic [7:0] seg;
        case (nibble)
            4'h0:    seg = 8'b1111_1100;
            4'h1:    seg = 8'b0110_0000;
            4'h2:    seg = 8'b1101_1010;
            4'h3:    seg = 8'b1111_0010;
            4'h4:    seg = 8'b0110_0110;
            4'h5:    seg = 8'b1011_0110;
            4'h6:    seg = 8'b1011_1110;
            4'h7:    seg = 8'b1110_0000;
            4'h8:    seg = 8'b1111_1110;
            4'h9:    seg = 8'b1111_0110;
            4'hA:    seg = 8'b1110_1110;
            4'hB:    seg = 8'b0011_1110;  // lower case b
            4'hC:    seg = 8'b1001_1100;
            4'hD:    seg = 8'b0111_1010;  // lower case d
            4'hE:    seg = 8'b1001_1110;
            default: seg = 8'b1000_1110;
        endcase
        return seg;
    endfunction

endpackage

// ==== rtl/tick_gen.sv ====
`timescale 1ns/1ns

module tick_gen
# (
    parameter int PERIOD = 4
)
(
    input  logic clk,
    input  logic arst_n,
    output logic tick
);

    localparam int CNT_W = (PERIOD > 1) ? $clog2(PERIOD) : 1;

    logic [CNT_W - 1:0] cnt_q;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            cnt_q <= CNT_W'(PERIOD - 1);
            tick  <= 1'b0;
        end
        else
        begin
            tick <= (cnt_q == '0);
            if (cnt_q == '0)
                cnt_q <= CNT_W'(PERIOD - 1);  // reload
            else
                cnt_q <= cnt_q - 1'b1;
        end
    end

endmodule

// ==== rtl/lab_counter.sv ====
`timescale 1ns/1ns

module lab_counter
(
    input  logic                clk,
    input  logic                arst_n,
    input  logic                tick,
    input  logic [7:0]          keys,
    output board_pkg::lab_out_t lab
);

    import board_pkg::*;

    logic [7:0] count_q;
    logic       phase_q;     // scan phase, 0 shows low nibble
    logic [3:0] nibble;

    assign nibble = phase_q ? count_q[7:4] : count_q[3:0];

    //------------------------------------------------------------------
    // count and scan phase

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            count_q <= 8'h00;
            phase_q <= 1'b0;
        end
        else
        begin
            if (keys[1])
                count_q <= 8'h00;             // clear wins
            else if (tick && keys[0])
                count_q <= count_q + 8'h01;

            if (tick)
                phase_q <= ~phase_q;
        end
    end

    //------------------------------------------------------------------
    // registered outputs one cycle behind the count

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            lab <= '0;
        end
        else
        begin
            lab.count    <= count_q;
            lab.abcdefgh <= seg7_hex(nibble);
            lab.digit    <= phase_q ? 8'b0000_0010 : 8'b0000_0001;
            lab.led      <= count_q;
        end
    end

endmodule

// ==== tm1638/tm1638_shifter.sv ====
`timescale 1ns/1ns

module tm1638_shifter
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       half_tick,

    input  logic       byte_start,
    input  logic       byte_read,
    input  logic [7:0] tx_byte,
    output logic       byte_done,
    output logic [7:0] rx_byte,

    output logic       sio_clk,
    output logic       sio_data_out,
    output logic       sio_data_oe,
    input  logic       sio_data_in
);

    logic       busy_q;
    logic       read_q;
    logic [2:0] bit_q;
    logic [7:0] shift_q;
    logic       rise;

    assign rise    = busy_q && half_tick && !sio_clk;   // mid-bit edge
    assign rx_byte = shift_q;

    //------------------------------------------------------------------
    // bit control and pins

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            busy_q       <= 1'b0;
            read_q       <= 1'b0;
            bit_q        <= 3'd0;
            byte_done    <= 1'b0;
            sio_clk      <= 1'b1;
            sio_data_out <= 1'b0;
            sio_data_oe  <= 1'b0;
        end
        else
        begin
            byte_done <= 1'b0;
            if (byte_start)
            begin
                busy_q      <= 1'b1;
                read_q      <= byte_read;
                bit_q       <= 3'd0;
                sio_data_oe <= ~byte_read;       // release the line for key reads
            end
            else if (busy_q && half_tick)
            begin
                sio_clk <= ~sio_clk;
                if (sio_clk)
                    sio_data_out <= shift_q[0] & ~read_q;   // change while clk low
                else
                begin
                    bit_q <= bit_q + 3'd1;
                    if (bit_q == 3'd7)
                    begin
                        busy_q    <= 1'b0;
                        byte_done <= 1'b1;
                    end
                end
            end
        end
    end

    // lsb first in both directions
    always_ff @(posedge clk)
    begin
        if (byte_start)
            shift_q <= tx_byte;
        else if (rise)
            shift_q <= {read_q & sio_data_in, shift_q[7:1]};
    end

endmodule

// ==== tm1638/tm1638_sequencer.sv ====
`timescale 1ns/1ns

`include "board_cfg.svh"

module tm1638_sequencer
(
    input  logic                   clk,
    input  logic                   arst_n,
    input  board_pkg::disp_frame_t frame,
    input  logic                   byte_done,
    input  logic [7:0]             rx_byte,
    output logic                   byte_start,
    output logic                   byte_read,
    output logic [7:0]             tx_byte,
    output logic                   sio_stb,
    output logic                   frame_load,
    output logic [7:0]             keys
);

    import board_pkg::*;

    localparam int HALF   = `SIO_HALF_CYCLES;
    localparam int GAP    = 2 * HALF;
    localparam int WAIT_W = $clog2(GAP + 1);

    tm_state_e           state_q;
    logic [4:0]          idx_q;        // byte index inside data or key phase
    logic [WAIT_W - 1:0] wait_q;
    logic                flight_q;     // byte handed to the shifter
    logic [7:0]          key_buf_q;
    logic [7:0]          key_nxt;
    logic [7:0]          next_byte;
    logic [2:0]          digit;
    logic                byte_state;
    logic                issue;
    logic                finish;

    assign digit      = idx_q[3:1];
    assign byte_state = state_q inside {st_cmd_write, st_addr, st_data,
                                        st_cmd_disp, st_cmd_read, st_keys};
    assign issue      = byte_state && (wait_q == '0) && !flight_q;
    assign finish     = byte_state && flight_q && byte_done;
    assign frame_load = (state_q == st_idle);

    always_comb
    begin
        next_byte = 8'h00;                   // key reads shift in
        case (state_q)
            st_cmd_write: next_byte = cmd_write_auto;
            st_addr:      next_byte = cmd_addr0;
            st_cmd_disp:  next_byte = cmd_disp_on;
            st_cmd_read:  next_byte = cmd_read_keys;
            st_data:
                if (!idx_q[0])
                    next_byte = frame.digit_en[digit] ? frame.segments[digit] : 8'h00;
                else
                    next_byte = {7'b0, frame.leds[digit]};
            default:      next_byte = 8'h00;
        endcase
    end

    // read byte k carries key 2k in bit 0 and key 2k+1 in bit 4
    always_comb
    begin
        key_nxt                     = key_buf_q;
        key_nxt[{idx_q[1:0], 1'b0}] = rx_byte[0];
        key_nxt[{idx_q[1:0], 1'b1}] = rx_byte[4];
    end

    //------------------------------------------------------------------

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state_q    <= st_idle;
            idx_q      <= '0;
            wait_q     <= '0;
            flight_q   <= 1'b0;
            byte_start <= 1'b0;
            byte_read  <= 1'b0;
            tx_byte    <= 8'h00;
            sio_stb    <= 1'b1;
            key_buf_q  <= 8'h00;
            keys       <= 8'h00;
        end
        else
        begin
            byte_start <= 1'b0;
            if (wait_q != '0)
                wait_q <= wait_q - 1'b1;

            if (issue)
            begin
                byte_start <= 1'b1;
                byte_read  <= (state_q == st_keys);
                tx_byte    <= next_byte;
                flight_q   <= 1'b1;
            end
            if (finish)
                flight_q <= 1'b0;

            case (state_q)
                st_idle:
                begin
                    state_q <= st_cmd_write;
                    sio_stb <= 1'b0;
                    wait_q  <= WAIT_W'(HALF - 1);   // stb lead before first bit
                end
                st_cmd_write, st_cmd_disp:
                    if (finish)
                    begin
                        state_q <= (state_q == st_cmd_write) ? st_stb_gap1 : st_stb_gap3;
                        sio_stb <= 1'b1;
                        wait_q  <= WAIT_W'(GAP - 1);
                    end
                st_stb_gap1, st_stb_gap2, st_stb_gap3:
                    if (wait_q == '0)
                    begin
                        case (state_q)
                            st_stb_gap1: state_q <= st_addr;
                            st_stb_gap2: state_q <= st_cmd_disp;
                            default:     state_q <= st_cmd_read;
                        endcase
                        sio_stb <= 1'b0;
                        wait_q  <= WAIT_W'(HALF - 1);
                    end
                st_addr, st_cmd_read:
                    if (finish)
                    begin
                        state_q <= (state_q == st_addr) ? st_data : st_keys;
                        idx_q   <= '0;
                    end
                st_data:
                    if (finish)
                    begin
                        idx_q <= idx_q + 1'b1;
                        if (idx_q == 5'(`TM_DATA_BYTES - 1))
                        begin
                            state_q <= st_stb_gap2;
                            sio_stb <= 1'b1;
                            wait_q  <= WAIT_W'(GAP - 1);
                        end
                    end
                st_keys:
                    if (finish)
                    begin
                        idx_q     <= idx_q + 1'b1;
                        key_buf_q <= key_nxt;
                        if (idx_q == 5'(`TM_KEY_BYTES - 1))
                        begin
                            keys    <= key_nxt;
                            state_q <= st_stb_gap4;
                            sio_stb <= 1'b1;
                            wait_q  <= WAIT_W'(GAP - 1);
                        end
                    end
                st_stb_gap4:
                    if (wait_q == '0)
                        state_q <= st_idle;          // next round
                default:
                    state_q <= st_idle;
            endcase
        end
    end

endmodule

// ==== tm1638/tm1638_controller.sv ====
`timescale 1ns/1ns

`include "board_cfg.svh"

module tm1638_controller
(
    input  logic                   clk,
    input  logic                   arst_n,
    input  board_pkg::disp_frame_t frame,
    output logic [7:0]             keys,

    output logic                   sio_clk,
    output logic                   sio_stb,
    output logic                   sio_data_out,
    output logic                   sio_data_oe,
    input  logic                   sio_data_in
);

    import board_pkg::*;

    disp_frame_t frame_q;        // held for a whole round
    logic        frame_load;
    logic        half_tick;
    logic        byte_start;
    logic        byte_read;
    logic        byte_done;
    logic [7:0]  tx_byte;
    logic [7:0]  rx_byte;

    tick_gen # (.PERIOD (`SIO_HALF_CYCLES))
    i_half_timer (.clk (clk), .arst_n (arst_n), .tick (half_tick));

    always_ff @(posedge clk)
    begin
        if (frame_load)
            frame_q <= frame;
    end

    tm1638_sequencer i_sequencer
    (
        .clk (clk), .arst_n (arst_n), .frame (frame_q),
        .byte_done (byte_done), .rx_byte (rx_byte),
        .byte_start (byte_start), .byte_read (byte_read), .tx_byte (tx_byte),
        .sio_stb (sio_stb), .frame_load (frame_load), .keys (keys)
    );

    tm1638_shifter i_shifter
    (
        .clk (clk), .arst_n (arst_n), .half_tick (half_tick),
        .byte_start (byte_start), .byte_read (byte_read), .tx_byte (tx_byte),
        .byte_done (byte_done), .rx_byte (rx_byte),
        .sio_clk (sio_clk), .sio_data_out (sio_data_out),
        .sio_data_oe (sio_data_oe), .sio_data_in (sio_data_in)
    );

endmodule

// ==== rtl/board_top.sv ====
`timescale 1ns/1ns

`include "board_cfg.svh"

module board_top
(
    input  logic       clk,
    input  logic       arst_n,

    output logic [7:0] led,

    output logic       sio_clk,
    output logic       sio_stb,
    output logic       sio_data_out,
    output logic       sio_data_oe,
    input  logic       sio_data_in
);

    import board_pkg::*;

    logic             slow_tick;
    logic [7:0]       tm_keys;
    lab_out_t         lab;
    disp_frame_t      frame;

    logic [1:0][7:0]  hex_abcdefgh;
    logic [1:0][7:0]  hex_hgfedcba;

    //------------------------------------------------------------------

    tick_gen # (.PERIOD (`LAB_TICK_CYCLES))
    i_tick_gen (.clk (clk), .arst_n (arst_n), .tick (slow_tick));

    lab_counter i_lab_counter
    (
        .clk    ( clk       ),
        .arst_n ( arst_n    ),
        .tick   ( slow_tick ),
        .keys   ( tm_keys   ),
        .lab    ( lab       )
    );

    assign led = ~lab.led;   // on-board leds are active low

    //------------------------------------------------------------------
    // each TM1638 digit holds its own pattern, so both nibbles go out

    assign hex_abcdefgh[0] = seg7_hex(lab.count[3:0]);
    assign hex_abcdefgh[1] = seg7_hex(lab.count[7:4]);

    generate
        genvar d, i;

        for (d = 0; d < 2; d++)
        begin : dig
            for (i = 0; i < 8; i++)
            begin : seg
                assign hex_hgfedcba[d][i] = hex_abcdefgh[d][7 - i];
            end
        end
    endgenerate

    always_comb
    begin
        frame                   = '0;
        frame.segments[0]       = hex_hgfedcba[0];
        frame.segments[1]       = hex_hgfedcba[1];
        frame.leds              = lab.led;
        frame.digit_en[1:0]     = 2'b11;     // only the two count digits lit
    end

    //------------------------------------------------------------------

    tm1638_controller i_tm1638
    (
        .clk          ( clk          ),
        .arst_n       ( arst_n       ),
        .frame        ( frame        ),
        .keys         ( tm_keys      ),
        .sio_clk      ( sio_clk      ),
        .sio_stb      ( sio_stb      ),
        .sio_data_out ( sio_data_out ),
        .sio_data_oe  ( sio_data_oe  ),
        .sio_data_in  ( sio_data_in  )
    );

endmodule

// ==== verif/tb_board_top.sv ====
`timescale 1ns/1ns

`include "board_cfg.svh"

module tb_board_top;

    typedef enum logic [1:0] {
        rel_hold,
        rel_inc,
        rel_clear
    } rel_e;

    typedef struct packed {
        logic [31:0] read_word;     // key scan bytes 3..0 as the device returns them
        logic [3:0]  min_rounds;
        rel_e        rel;
    } stim_row_t;

    localparam int NUM_ROWS = 12;

    localparam stim_row_t STIM [NUM_ROWS] = '{
        '{32'h0000_0000, 4'd3,  rel_hold},
        '{32'h0000_0001, 4'd10, rel_inc},     // key 0
        '{32'h0000_0000, 4'd3,  rel_hold},
        '{32'h0000_0010, 4'd3,  rel_clear},   // key 1
        '{32'h0000_0011, 4'd3,  rel_clear},   // keys 0 and 1
        '{32'h0000_0001, 4'd10, rel_inc},
        '{32'h0000_0100, 4'd6,  rel_hold},    // key 2
        '{32'h0000_1000, 4'd6,  rel_hold},    // key 3
        '{32'h1000_0000, 4'd6,  rel_hold},    // key 7
        '{32'h0000_00EE, 4'd6,  rel_hold},    // bits that carry no key
        '{32'h0000_0010, 4'd3,  rel_clear},
        '{32'h0000_0000, 4'd3,  rel_hold}
    };

    // abcdefgh, a at the msb
    localparam logic [7:0] HEX_ABCDEFGH [16] = '{
        8'hFC, 8'h60, 8'hDA, 8'hF2, 8'h66, 8'hB6, 8'hBE, 8'hE0,
        8'hFE, 8'hF6, 8'hEE, 8'h3E, 8'h9C, 8'h7A, 8'h9E, 8'h8E
    };

    logic        clk = 1'b0;
    logic        arst_n = 1'b0;
    logic        sio_data_in = 1'b0;
    logic [7:0]  led;
    logic        sio_clk;
    logic        sio_stb;
    logic        sio_data_out;
    logic        sio_data_oe;

    // device model state
    logic [31:0] key_word = '0;
    logic        stb_prev = 1'b1;
    logic        clk_prev = 1'b1;
    logic        reading = 1'b0;
    logic [7:0]  shreg = '0;
    logic [7:0]  txn_cmd = '0;
    int          bit_cnt = 0;
    int          txn_bytes = 0;
    int          cmd_cnt = 0;
    int          data_cnt = 0;
    int          read_cnt = 0;
    int          extra_cnt = 0;
    logic [7:0]  cmd_log [4];
    logic [7:0]  data_buf [`TM_DATA_BYTES];

    // last finished round
    logic [7:0]  rnd_cmd [4];
    logic [7:0]  rnd_data [`TM_DATA_BYTES];
    int          rnd_cmd_cnt;
    int          rnd_data_cnt;
    int          rnd_read_cnt;
    int          rnd_extra_cnt;
    int          rounds_done = 0;
    int          rounds_taken = 0;
    longint      budget_cycles = 0;

    board_top i_board_top
    (
        .clk          ( clk          ),
        .arst_n       ( arst_n       ),
        .led          ( led          ),
        .sio_clk      ( sio_clk      ),
        .sio_stb      ( sio_stb      ),
        .sio_data_out ( sio_data_out ),
        .sio_data_oe  ( sio_data_oe  ),
        .sio_data_in  ( sio_data_in  )
    );

    initial
    begin
        forever #10 clk = ~clk;
    end

    //----------------------------------------------------------------------

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
            abort_run($sformatf("mismatch %s got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    function automatic logic [7:0] seg_hgfedcba(input logic [3:0] nibble);
        logic [7:0] abc;
        logic [7:0] rev;
        abc = HEX_ABCDEFGH[nibble];
        for (int i = 0; i < 8; i++)
            rev[i] = abc[7 - i];
        return rev;
    endfunction

    task automatic store_byte(input logic [7:0] b);
        if (txn_bytes == 0)
        begin
            txn_cmd = b;                           // first byte of a transaction
            if (cmd_cnt < 4)
                cmd_log[cmd_cnt] = b;
            cmd_cnt++;
            reading = (b == 8'h42);
        end
        else if (reading)
            read_cnt++;
        else if (txn_cmd == 8'hC0 && data_cnt < `TM_DATA_BYTES)
        begin
            data_buf[data_cnt] = b;
            data_cnt++;
        end
        else
            extra_cnt++;
        txn_bytes++;
    endtask

    task automatic finish_round();
        rnd_cmd       = cmd_log;
        rnd_data      = data_buf;
        rnd_cmd_cnt   = cmd_cnt;
        rnd_data_cnt  = data_cnt;
        rnd_read_cnt  = read_cnt;
        rnd_extra_cnt = extra_cnt;
        cmd_cnt       = 0;
        data_cnt      = 0;
        read_cnt      = 0;
        extra_cnt     = 0;
        rounds_done++;
    endtask

    //----------------------------------------------------------------------
    // TM1638 device model sampling pins between dut clock edges

    always @(negedge clk)
    begin
        if (stb_prev && !sio_stb)
        begin
            bit_cnt   = 0;
            txn_bytes = 0;
            reading   = 1'b0;
        end
        if (!sio_stb && clk_prev && !sio_clk && reading && read_cnt < `TM_KEY_BYTES)
            sio_data_in = key_word[8 * read_cnt + bit_cnt];   // next key bit
        if (!sio_stb && !clk_prev && sio_clk)
        begin
            check_value("sio_data_oe", sio_data_oe, !reading);
            shreg = {sio_data_out, shreg[7:1]};              // lsb first
            bit_cnt++;
            if (bit_cnt == 8)
            begin
                store_byte(shreg);
                bit_cnt = 0;
            end
        end
        if (!stb_prev && sio_stb)
        begin
            if (bit_cnt != 0)
                abort_run("TM1638 strobe rose in the middle of a byte");
            else if (reading)
                finish_round();
        end
        stb_prev = sio_stb;
        clk_prev = sio_clk;
    end

    // waits for the next round, checks its framing, returns the count it shows
    task automatic collect_round(output logic [7:0] v);
        logic [7:0] seg_exp;
        wait (rounds_done > rounds_taken);
        rounds_taken++;
        check_value("command count", rnd_cmd_cnt, 4);
        check_value("write command", rnd_cmd[0], 8'h40);
        check_value("address command", rnd_cmd[1], 8'hC0);
        check_value("display command", rnd_cmd[2], 8'h8F);
        check_value("read command", rnd_cmd[3], 8'h42);
        check_value("data byte count", rnd_data_cnt, `TM_DATA_BYTES);
        check_value("key byte count", rnd_read_cnt, `TM_KEY_BYTES);
        check_value("extra byte count", rnd_extra_cnt, 0);
        v = '0;
        for (int n = 0; n < `TM_DIGITS; n++)
            v[n] = rnd_data[2 * n + 1][0];
        for (int n = 0; n < `TM_DIGITS; n++)
        begin
            if (n == 0)
                seg_exp = seg_hgfedcba(v[3:0]);
            else if (n == 1)
                seg_exp = seg_hgfedcba(v[7:4]);
            else
                seg_exp = 8'h00;
            check_value($sformatf("led byte %0d", n), rnd_data[2 * n + 1], {7'b0, v[n]});
            check_value($sformatf("digit %0d segments", n), rnd_data[2 * n], seg_exp);
        end
    endtask

    //----------------------------------------------------------------------

    initial
    begin
        wait (budget_cycles > 0);
        repeat (budget_cycles) @(posedge clk);
        abort_run("no TM1638 round finished in time");
    end

    initial
    begin
        int         waits [NUM_ROWS];
        int         total;
        logic [7:0] v;
        logic [7:0] prev;
        logic [7:0] step;
        logic [7:0] span;
        logic [7:0] led_exp;
        logic [7:0] hist [16];

        void'($urandom(32'hfbd46653));
        total = 1;
        for (int r = 0; r < NUM_ROWS; r++)
        begin
            waits[r] = int'(STIM[r].min_rounds) + int'($urandom_range(0, 2));
            total += waits[r];
        end
        budget_cycles = longint'(total + 2) * 2000;   // a round is well under 2000 cycles

        repeat (2) @(negedge clk);
        check_value("sio_stb", sio_stb, 1);
        check_value("sio_clk", sio_clk, 1);
        check_value("sio_data_oe", sio_data_oe, 0);
        check_value("led", led, 8'hFF);
        arst_n = 1'b1;

        collect_round(v);
        check_value("count after reset", v, 0);
        prev = v;

        for (int r = 0; r < NUM_ROWS; r++)
        begin
            @(negedge clk);
            key_word = STIM[r].read_word;
            for (int k = 1; k <= waits[r]; k++)
            begin
                collect_round(v);
                hist[k] = v;
                step    = v - prev;
                led_exp = ~v;
                if (k >= 2)                       // first round still shows the old keys
                begin
                    case (STIM[r].rel)
                        rel_hold:
                        begin
                            check_value("led", led, led_exp);
                            if (k >= 3)           // round 1 still counted with the old keys
                                check_value("count", v, prev);
                        end
                        rel_clear:
                        begin
                            check_value("count", v, 8'h00);
                            check_value("led", led, 8'hFF);
                        end
                        default:
                        begin
                            if (step > 8'd1)
                                abort_run($sformatf("count rose by %0d within one round",
                                                    step));
                            if (k >= 10)
                            begin
                                span = v - hist[k - 8];
                                if (span == 8'd0)
                                    abort_run("count did not rise over 8 rounds with key 0");
                            end
                        end
                    endcase
                end
                prev = v;
            end
        end

        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+common
common/board_pkg.sv
rtl/tick_gen.sv
rtl/lab_counter.sv
tm1638/tm1638_shifter.sv
tm1638/tm1638_sequencer.sv
tm1638/tm1638_controller.sv
rtl/board_top.sv
verif/tb_board_top.sv

// ==== Makefile ====
TOP := tb_board_top

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal -f files.f --top-module $(TOP) --Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
